//--- intCtlPkg.sv
//********************
// shared widths, register map, address decode and handoff states
// modules take these with a wildcard import of intCtlPkg in their header
//********************
package intCtlPkg;

    // register and address widths
    localparam int RegWidth  = 32;
    localparam int AddrWidth = 10;

    // bank geometry, one block of words per scalar/SIMT pair
    localparam int NumPairs     = 4;
    localparam int WordsPerPair = 8;

    // byte address fields, bits 4:2 pick the word and 9:5 the block
    localparam int WordLsb       = 2;
    localparam int WordIdxWidth  = $clog2(WordsPerPair);
    localparam int BlockLsb      = WordLsb + WordIdxWidth;
    localparam int BlockIdxWidth = AddrWidth - BlockLsb;
    localparam int PairIdxWidth  = $clog2(NumPairs);

    typedef logic [RegWidth-1:0]      regWord_t;
    typedef logic [AddrWidth-1:0]     regAddr_t;
    typedef logic [WordIdxWidth-1:0]  wordIdx_t;
    typedef logic [BlockIdxWidth-1:0] blockIdx_t;
    typedef logic [PairIdxWidth-1:0]  pairIdx_t;

    //********************
    // word offsets inside a block
    //********************
    localparam wordIdx_t OffAccel = 3'd0;
    localparam wordIdx_t OffIpc   = 3'd1;
    localparam wordIdx_t OffError = 3'd2;
    localparam wordIdx_t OffS2v   = 3'd3;
    localparam wordIdx_t OffTid   = 3'd4;
    localparam wordIdx_t OffIrq   = 3'd5;
    localparam wordIdx_t OffSp    = 3'd6;
    localparam wordIdx_t OffSpare = 3'd7;

    // handoff sequence of the pair 0 state machine
    typedef enum logic [2:0] {
        Idle,
        WaitDrain,
        PcSwap,
        WaitIrq,
        RevertWarp
    } handoffState_t;

    //********************
    // address decode helpers
    //********************
    function automatic wordIdx_t wordOf(input regAddr_t addr);
        return addr[BlockLsb-1:WordLsb];
    endfunction

    function automatic blockIdx_t blockOf(input regAddr_t addr);
        return addr[AddrWidth-1:BlockLsb];
    endfunction

    // only the low bits of the block field index the storage
    function automatic pairIdx_t pairOf(input regAddr_t addr);
        blockIdx_t blk;
        blk = blockOf(addr);
        return blk[PairIdxWidth-1:0];
    endfunction

    function automatic logic blockValid(input regAddr_t addr);
        return blockOf(addr) < BlockIdxWidth'(NumPairs);
    endfunction

endpackage

//--- intRegBank.sv
//********************
// interrupt register bank with a scalar port and a SIMT port
// block 0 also takes update strobes from the handoff state machine
//********************
`timescale 1ns/1ps

module intRegBank import intCtlPkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // scalar core access
    input  logic     scalarRd,
    input  logic     scalarWr,
    input  regAddr_t scalarAddr,
    input  regWord_t scalarStore,
    output regWord_t scalarLoad,

    // SIMT core access
    input  logic     simtRd,
    input  logic     simtWr,
    input  regAddr_t simtAddr,
    input  regWord_t simtStore,
    output regWord_t simtLoad,

    // hardware updates of block 0
    input  logic     errorSet,
    input  logic     errorClear,
    input  logic     s2vClear,
    input  logic     ipcCapture,
    input  regWord_t warpPc,

    // block 0 values seen by the state machine
    output regWord_t s2vWord,
    output regWord_t irqWord,
    output regWord_t ipcWord
);

    // NumPairs blocks of WordsPerPair words
    regWord_t mem [NumPairs][WordsPerPair];

    pairIdx_t scalarPair;
    wordIdx_t scalarWord;
    logic     scalarValid;

    pairIdx_t simtPair;
    wordIdx_t simtWord;
    logic     simtValid;

    //********************
    // address decode
    //********************
    assign scalarPair  = pairOf(scalarAddr);
    assign scalarWord  = wordOf(scalarAddr);
    assign scalarValid = blockValid(scalarAddr);

    assign simtPair  = pairOf(simtAddr);
    assign simtWord  = wordOf(simtAddr);
    assign simtValid = blockValid(simtAddr);

    //********************
    // reads
    //********************
    // loads are combinational and read 0 while the strobe is low
    assign scalarLoad = (scalarRd && scalarValid) ? mem[scalarPair][scalarWord] : '0;
    assign simtLoad   = (simtRd && simtValid) ? mem[simtPair][simtWord] : '0;

    // pair 0 taps for the handoff logic
    assign s2vWord = mem[0][OffS2v];
    assign irqWord = mem[0][OffIrq];
    assign ipcWord = mem[0][OffIpc];

    //********************
    // writes
    //********************
    // later assignments win, so the order below is the priority
    // scalar first, then SIMT, then the block 0 hardware strobes
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem <= '{default: '0};
        end
        else
        begin
            if (scalarWr && scalarValid)
            begin
                mem[scalarPair][scalarWord] <= scalarStore;
            end

            if (simtWr && simtValid)
            begin
                mem[simtPair][simtWord] <= simtStore;
            end

            // error word, set on a failed drain and cleared on a new request
            if (errorSet)
            begin
                mem[0][OffError] <= regWord_t'(1);
            end
            else if (errorClear)
            begin
                mem[0][OffError] <= '0;
            end

            // acknowledge of a failed request
            if (s2vClear)
            begin
                mem[0][OffS2v] <= '0;
            end

            // interrupted PC of the warp
            if (ipcCapture)
            begin
                mem[0][OffIpc] <= warpPc;
            end
        end
    end

    //********************
    // assertions
    //********************
    // software only addresses blocks that exist
    scalarBlockInRange: assert property (
        @(posedge clk) disable iff (reset)
        (scalarRd || scalarWr) |-> scalarValid
    ) else $error("scalar access to block %0d beyond NumPairs", blockOf(scalarAddr));

    simtBlockInRange: assert property (
        @(posedge clk) disable iff (reset)
        (simtRd || simtWr) |-> simtValid
    ) else $error("SIMT access to block %0d beyond NumPairs", blockOf(simtAddr));

    // the state machine never both sets and clears the error word
    errorStrobesExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(errorSet && errorClear)
    ) else $error("errorSet and errorClear high together");

endmodule

//--- threadHandoffFsm.sv
//********************
// pair 0 handoff FSM that moves a warp thread onto the IRQ vector
// steered by the S2V word and drives the warp controls and bank strobes
//********************
`timescale 1ns/1ps

module threadHandoffFsm import intCtlPkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // pipeline status
    input  logic     pipeClean,
    input  logic     err,

    // block 0 values from the register bank
    input  regWord_t s2vWord,
    input  regWord_t irqWord,
    input  regWord_t ipcWord,

    // warp controls
    output logic     maskActWarp,
    output logic     hwInt,
    output logic     maskThreads,
    output logic     swapPc,
    output logic     restorePc,
    output regWord_t targetPc,

    // register update strobes, each acts at the next edge
    output logic     errorSet,
    output logic     errorClear,
    output logic     s2vClear,
    output logic     ipcCapture
);

    handoffState_t state;
    handoffState_t nextState;

    logic s2vSet;

    // a request is a 1 in S2V, a release is a 0
    assign s2vSet = (s2vWord == regWord_t'(1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= Idle;
        end
        else
        begin
            state <= nextState;
        end
    end

    //********************
    // next state and outputs
    //********************
    always_comb
    begin
        nextState   = state;
        maskActWarp = 1'b0;
        hwInt       = 1'b0;
        maskThreads = 1'b0;
        swapPc      = 1'b0;
        restorePc   = 1'b0;
        targetPc    = '0;
        errorSet    = 1'b0;
        errorClear  = 1'b0;
        s2vClear    = 1'b0;
        ipcCapture  = 1'b0;

        case (state)
            Idle:
            begin
                // a fresh request wipes the old error result
                if (s2vSet)
                begin
                    errorClear = 1'b1;
                    nextState  = WaitDrain;
                end
            end
            WaitDrain:
            begin
                maskActWarp = 1'b1;
                hwInt       = 1'b1;
                // err wins over pipeClean
                if (err)
                begin
                    errorSet  = 1'b1;
                    s2vClear  = 1'b1;
                    nextState = Idle;
                end
                else if (pipeClean)
                begin
                    nextState = PcSwap;
                end
            end
            PcSwap:
            begin
                hwInt       = 1'b1;
                maskThreads = 1'b1;
                swapPc      = 1'b1;
                targetPc    = irqWord;
                ipcCapture  = 1'b1;
                nextState   = WaitIrq;
            end
            WaitIrq:
            begin
                hwInt       = 1'b1;
                maskThreads = 1'b1;
                if (!(|s2vWord))
                begin
                    nextState = RevertWarp;
                end
            end
            RevertWarp:
            begin
                // one cycle to put the saved PC back
                restorePc = 1'b1;
                targetPc  = ipcWord;
                nextState = Idle;
            end
            default:
            begin
                nextState = Idle;
            end
        endcase
    end

    //********************
    // assertions
    //********************
    // threads stay masked in the cycle after the PC swap
    swapThenMask: assert property (
        @(posedge clk) disable iff (reset)
        swapPc |=> maskThreads
    ) else $error("maskThreads low after swapPc");

    swapRestoreExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(swapPc && restorePc)
    ) else $error("swapPc and restorePc high together");

endmodule

//--- intController.sv
//********************
// interrupt controller top, register bank plus the pair 0 handoff FSM
//********************
`timescale 1ns/1ps

module intController import intCtlPkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // scalar core port
    input  logic     scalarRd,
    input  logic     scalarWr,
    input  regAddr_t scalarAddr,
    input  regWord_t scalarStore,
    output regWord_t scalarLoad,

    // SIMT core port
    input  logic     simtRd,
    input  logic     simtWr,
    input  regAddr_t simtAddr,
    input  regWord_t simtStore,
    output regWord_t simtLoad,

    // pipeline status
    input  logic     pipeClean,
    input  logic     err,
    input  regWord_t warpPc,

    // warp controls
    output logic     maskActWarp,
    output logic     hwInt,
    output logic     maskThreads,
    output logic     swapPc,
    output logic     restorePc,
    output regWord_t targetPc
);

    // block 0 values toward the FSM
    regWord_t s2vWord;
    regWord_t irqWord;
    regWord_t ipcWord;

    // FSM update strobes toward the bank
    logic errorSet;
    logic errorClear;
    logic s2vClear;
    logic ipcCapture;

    intRegBank regBank (
        .clk         (clk),
        .reset       (reset),
        .scalarRd    (scalarRd),
        .scalarWr    (scalarWr),
        .scalarAddr  (scalarAddr),
        .scalarStore (scalarStore),
        .scalarLoad  (scalarLoad),
        .simtRd      (simtRd),
        .simtWr      (simtWr),
        .simtAddr    (simtAddr),
        .simtStore   (simtStore),
        .simtLoad    (simtLoad),
        .errorSet    (errorSet),
        .errorClear  (errorClear),
        .s2vClear    (s2vClear),
        .ipcCapture  (ipcCapture),
        .warpPc      (warpPc),
        .s2vWord     (s2vWord),
        .irqWord     (irqWord),
        .ipcWord     (ipcWord)
    );

    threadHandoffFsm handoffFsm (
        .clk         (clk),
        .reset       (reset),
        .pipeClean   (pipeClean),
        .err         (err),
        .s2vWord     (s2vWord),
        .irqWord     (irqWord),
        .ipcWord     (ipcWord),
        .maskActWarp (maskActWarp),
        .hwInt       (hwInt),
        .maskThreads (maskThreads),
        .swapPc      (swapPc),
        .restorePc   (restorePc),
        .targetPc    (targetPc),
        .errorSet    (errorSet),
        .errorClear  (errorClear),
        .s2vClear    (s2vClear),
        .ipcCapture  (ipcCapture)
    );

endmodule

//--- tbIntController.sv
//********************
// testbench for the interrupt controller with a shadow bank and an FSM model
// LFSR register traffic followed by a good and a failed thread handoff
//********************
`timescale 1ns/1ps

module tbIntController import intCtlPkg::*;
();

    logic     clk;
    logic     reset;
    logic     scalarRd;
    logic     scalarWr;
    regAddr_t scalarAddr;
    regWord_t scalarStore;
    regWord_t scalarLoad;
    logic     simtRd;
    logic     simtWr;
    regAddr_t simtAddr;
    regWord_t simtStore;
    regWord_t simtLoad;
    logic     pipeClean;
    logic     err;
    regWord_t warpPc;
    logic     maskActWarp;
    logic     hwInt;
    logic     maskThreads;
    logic     swapPc;
    logic     restorePc;
    regWord_t targetPc;

    // expected bank contents and expected handoff state
    regWord_t      shadow [NumPairs][WordsPerPair];
    handoffState_t expState;
    logic [15:0]   lfsr;

    intController i_intController (.*);

    always #20 clk = ~clk;

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic regAddr_t wordAddr(input logic [1:0] blk, input wordIdx_t word);
        return {3'b000, blk, word, 2'b00};
    endfunction

    function automatic regWord_t expectedLoad(input logic rd, input regAddr_t addr);
        return rd ? shadow[addr[6:5]][addr[4:2]] : '0;
    endfunction

    function automatic logic controlValue(input string name);
        if (name == "swapPc")
            return swapPc;
        else if (name == "restorePc")
            return restorePc;
        return hwInt;
    endfunction

    task automatic reportMismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "check failed");
    endtask

    // polls on falling edges until the control reaches level
    task automatic awaitControl(input string name, input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (controlValue(name) != level && cycles < limit)
        begin
            @(negedge clk);
            cycles++;
        end
        if (controlValue(name) != level)
        begin
            $display("Timeout: %s did not reach %0b within %0d cycles", name, level, limit);
            $display("Simulation failed");
            $fatal(1, "wait timed out");
        end
    endtask

    //********************
    // bus tasks start and end on a falling edge
    //********************
    task automatic scalarWrite(input regAddr_t addr, input regWord_t data);
        scalarWr    = 1'b1;
        scalarAddr  = addr;
        scalarStore = data;
        @(negedge clk);
        scalarWr = 1'b0;
    endtask

    task automatic simtWrite(input regAddr_t addr, input regWord_t data);
        simtWr    = 1'b1;
        simtAddr  = addr;
        simtStore = data;
        @(negedge clk);
        simtWr = 1'b0;
    endtask

    task automatic readBoth(input regAddr_t addr);
        scalarRd   = 1'b1;
        simtRd     = 1'b1;
        scalarAddr = addr;
        simtAddr   = addr;
        @(negedge clk);
        scalarRd = 1'b0;
        simtRd   = 1'b0;
    endtask

    task automatic requestHandoff();
        scalarWrite(wordAddr(2'd0, OffS2v), regWord_t'(1));
        awaitControl("hwInt", 1'b1, 10);
    endtask

    // drain, swap, hold in WaitIrq, release by software and restore
    task automatic completeHandoff();
        @(negedge clk);
        pipeClean = 1'b1;
        awaitControl("swapPc", 1'b1, 10);
        pipeClean = 1'b0;
        @(negedge clk);
        warpPc = regWord_t'(randomBits(32));
        readBoth(wordAddr(2'd0, OffIpc));
        repeat (3) @(negedge clk);
        simtWrite(wordAddr(2'd0, OffS2v), '0);
        awaitControl("restorePc", 1'b1, 10);
        @(negedge clk);
    endtask

    //********************
    // concurrent checks
    //********************
    swapOneCycle: assert property (@(posedge clk) disable iff (reset) swapPc |=> !swapPc)
        else reportMismatch("swapPc high for more than one cycle");

    restoreThenQuiet: assert property (@(posedge clk) disable iff (reset)
        restorePc |=> !(maskActWarp || hwInt || maskThreads || swapPc || restorePc))
        else reportMismatch("controls not all low after restorePc");

    failDropsHwInt: assert property (@(posedge clk) disable iff (reset)
        (maskActWarp && err) |=> !hwInt)
        else reportMismatch("hwInt still high after err during drain");

    // compare outputs with the model, then advance the model
    always @(posedge clk)
    begin
        logic [4:0]    expCtl;
        regWord_t      expTarget;
        logic          setErr;
        logic          clrErr;
        logic          clrS2v;
        logic          capIpc;
        handoffState_t nextExp;
        if (reset)
        begin
            shadow   = '{default: '0};
            expState = Idle;
        end
        else
        begin
            expCtl = {expState == WaitDrain, expState inside {WaitDrain, PcSwap, WaitIrq},
                      expState inside {PcSwap, WaitIrq}, expState == PcSwap,
                      expState == RevertWarp};
            expTarget = (expState == PcSwap) ? shadow[0][OffIrq] :
                        (expState == RevertWarp) ? shadow[0][OffIpc] : '0;
            ctlCheck: assert ({maskActWarp, hwInt, maskThreads, swapPc, restorePc} == expCtl)
                else reportMismatch($sformatf("controls %b, expected %b",
                    {maskActWarp, hwInt, maskThreads, swapPc, restorePc}, expCtl));
            targetCheck: assert (targetPc == expTarget)
                else reportMismatch($sformatf("targetPc %h, expected %h", targetPc, expTarget));
            scalarCheck: assert (scalarLoad == expectedLoad(scalarRd, scalarAddr))
                else reportMismatch($sformatf("scalarLoad %h at %h, expected %h", scalarLoad,
                    scalarAddr, expectedLoad(scalarRd, scalarAddr)));
            simtCheck: assert (simtLoad == expectedLoad(simtRd, simtAddr))
                else reportMismatch($sformatf("simtLoad %h at %h, expected %h", simtLoad,
                    simtAddr, expectedLoad(simtRd, simtAddr)));

            nextExp = expState;
            setErr  = 1'b0;
            clrErr  = 1'b0;
            clrS2v  = 1'b0;
            capIpc  = 1'b0;
            case (expState)
                Idle:
                begin
                    clrErr  = (shadow[0][OffS2v] == regWord_t'(1));
                    nextExp = clrErr ? WaitDrain : Idle;
                end
                WaitDrain:
                begin
                    setErr  = err;
                    clrS2v  = err;
                    nextExp = err ? Idle : (pipeClean ? PcSwap : WaitDrain);
                end
                PcSwap:
                begin
                    capIpc  = 1'b1;
                    nextExp = WaitIrq;
                end
                WaitIrq:
                    nextExp = (shadow[0][OffS2v] == '0) ? RevertWarp : WaitIrq;
                default:
                    nextExp = Idle;
            endcase

            // scalar, then SIMT, then the block 0 hardware updates
            if (scalarWr)
                shadow[scalarAddr[6:5]][scalarAddr[4:2]] = scalarStore;
            if (simtWr)
                shadow[simtAddr[6:5]][simtAddr[4:2]] = simtStore;
            if (setErr)
                shadow[0][OffError] = regWord_t'(1);
            else if (clrErr)
                shadow[0][OffError] = '0;
            if (clrS2v)
                shadow[0][OffS2v] = '0;
            if (capIpc)
                shadow[0][OffIpc] = warpPc;
            expState = nextExp;
        end
    end

    //********************
    // stimulus
    //********************
    initial
    begin
        logic [1:0] blk;
        wordIdx_t   word;
        clk         = 1'b0;
        reset       = 1'b1;
        scalarRd    = 1'b0;
        scalarWr    = 1'b0;
        scalarAddr  = '0;
        scalarStore = '0;
        simtRd      = 1'b0;
        simtWr      = 1'b0;
        simtAddr    = '0;
        simtStore   = '0;
        pipeClean   = 1'b0;
        err         = 1'b0;
        warpPc      = '0;
        lfsr        = 16'd64;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // every word reads 0 after reset
        for (int b = 0; b < NumPairs; b++)
            for (int w = 0; w < WordsPerPair; w++)
                readBoth(wordAddr(2'(b), wordIdx_t'(w)));

        // random traffic keeps S2V of block 0 out of it
        for (int i = 0; i < 40; i++)
        begin
            blk  = 2'(randomBits(2));
            word = wordIdx_t'(randomBits(3));
            if (blk == 2'd0 && word == OffS2v)
                word = OffSpare;
            if (randomBits(1) == 32'd1)
                scalarWrite(wordAddr(blk, word), regWord_t'(randomBits(32)));
            else
                simtWrite(wordAddr(blk, word), regWord_t'(randomBits(32)));
            readBoth(wordAddr(blk, word));
        end

        // SIMT wins when both ports write the same word
        scalarWr    = 1'b1;
        simtWr      = 1'b1;
        scalarAddr  = wordAddr(2'd2, OffTid);
        simtAddr    = wordAddr(2'd2, OffTid);
        scalarStore = regWord_t'(randomBits(32));
        simtStore   = regWord_t'(randomBits(32));
        @(negedge clk);
        scalarWr = 1'b0;
        simtWr   = 1'b0;
        readBoth(wordAddr(2'd2, OffTid));

        // successful handoff
        scalarWrite(wordAddr(2'd0, OffIrq), regWord_t'(randomBits(32)));
        warpPc = regWord_t'(randomBits(32));
        requestHandoff();
        completeHandoff();

        // failed handoff where err beats pipeClean and FSM updates beat software writes
        requestHandoff();
        err         = 1'b1;
        pipeClean   = 1'b1;
        scalarWr    = 1'b1;
        scalarAddr  = wordAddr(2'd0, OffError);
        scalarStore = regWord_t'(randomBits(32));
        simtWr      = 1'b1;
        simtAddr    = wordAddr(2'd0, OffS2v);
        simtStore   = regWord_t'(2);
        @(negedge clk);
        err       = 1'b0;
        pipeClean = 1'b0;
        scalarWr  = 1'b0;
        simtWr    = 1'b0;
        awaitControl("hwInt", 1'b0, 5);
        readBoth(wordAddr(2'd0, OffError));
        readBoth(wordAddr(2'd0, OffS2v));

        // a new request clears error on entry to WaitDrain
        requestHandoff();
        readBoth(wordAddr(2'd0, OffError));
        completeHandoff();

        repeat (4) @(negedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- tb.f
intCtlPkg.sv
intRegBank.sv
threadHandoffFsm.sv
intController.sv
tbIntController.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert
TOP       ?= tbIntController
FILELIST  ?= tb.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir
